/* common/rfsim_pkg.sv */
`default_nettype none

package rfsim_pkg;

	// local register bus
	localparam int wb_addr_w = 4;
	localparam int wb_data_w = 32;

	// dac beat geometry
	localparam int dac_lanes = 4;
	localparam int dac_lane_w = 64;
	localparam int dac_data_w = dac_lanes * dac_lane_w;
	localparam int dac_strb_w = dac_data_w / 8;

	// one 16-bit sample kept per lane
	localparam int sample_w = 16;
	localparam int adc_data_w = dac_lanes * sample_w;
	localparam int adc_strb_w = adc_data_w / 8;

	// word addresses of the register map
	localparam logic [wb_addr_w-1:0] reg_cfg_resets = 4'd0;
	localparam logic [wb_addr_w-1:0] reg_dsp_resets = 4'd1;
	localparam logic [wb_addr_w-1:0] reg_loop_ctrl = 4'd2;
	localparam logic [wb_addr_w-1:0] reg_id = 4'd3;

	// reset values, all subsystems held in reset
	localparam logic [wb_data_w-1:0] resets_init = '0;
	localparam logic loop_en_init = 1'b0;

	// read-only identification word
	localparam logic [wb_data_w-1:0] rfsim_id = 32'h5f51_0001;

	// one dac lane, only the low sample is carried on
	typedef struct packed {
		logic [dac_lane_w-sample_w-1:0] unused;
		logic [sample_w-1:0] sample;
	} dac_lane_t;

	// dac beat, flat bus or per-lane view
	// lane 0 sits in the lowest bits
	typedef union packed {
		logic [dac_data_w-1:0] flat;
		dac_lane_t [dac_lanes-1:0] lane;
	} dac_beat_u;

endpackage

`default_nettype wire

/* src/wb_arbiter.sv */
`default_nettype none

module wb_arbiter (
	input wire pl_clk0,
	input wire rst_n,

	// cfg host port
	input wire cfg_cyc,
	input wire cfg_stb,
	input wire cfg_we,
	input wire [rfsim_pkg::wb_addr_w-1:0] cfg_adr,
	input wire [rfsim_pkg::wb_data_w-1:0] cfg_dat_w,
	output logic [rfsim_pkg::wb_data_w-1:0] cfg_dat_r,
	output logic cfg_ack,

	// dsp host port
	input wire dsp_cyc,
	input wire dsp_stb,
	input wire dsp_we,
	input wire [rfsim_pkg::wb_addr_w-1:0] dsp_adr,
	input wire [rfsim_pkg::wb_data_w-1:0] dsp_dat_w,
	output logic [rfsim_pkg::wb_data_w-1:0] dsp_dat_r,
	output logic dsp_ack,

	// shared local bus
	output logic loc_cyc,
	output logic loc_stb,
	output logic loc_we,
	output logic [rfsim_pkg::wb_addr_w-1:0] loc_adr,
	output logic [rfsim_pkg::wb_data_w-1:0] loc_dat_w,
	input wire [rfsim_pkg::wb_data_w-1:0] loc_dat_r,
	input wire loc_ack
);

	// owner encoding
	localparam logic [1:0] own_idle = 2'd0;
	localparam logic [1:0] own_cfg = 2'd1;
	localparam logic [1:0] own_dsp = 2'd2;

	logic [1:0] owner;
	logic [1:0] owner_nxt;

	// grant held until the owner drops cyc
	always_comb begin
		owner_nxt = owner;
		case (owner)
			own_cfg: begin
				if (!cfg_cyc)
					owner_nxt = own_idle;
			end
			own_dsp: begin
				if (!dsp_cyc)
					owner_nxt = own_idle;
			end
			default: begin
				// idle, cfg wins a tie
				if (cfg_cyc)
					owner_nxt = own_cfg;
				else if (dsp_cyc)
					owner_nxt = own_dsp;
				else
					owner_nxt = own_idle;
			end
		endcase
	end

	always_ff @(posedge pl_clk0 or negedge rst_n) begin
		if (!rst_n) begin
			owner <= own_idle;
		end else begin
			owner <= owner_nxt;
		end
	end

	// only the owner's request reaches the local bus
	always_comb begin
		loc_cyc = 1'b0;
		loc_stb = 1'b0;
		loc_we = 1'b0;
		loc_adr = '0;
		loc_dat_w = '0;
		case (owner)
			own_cfg: begin
				loc_cyc = cfg_cyc;
				loc_stb = cfg_stb;
				loc_we = cfg_we;
				loc_adr = cfg_adr;
				loc_dat_w = cfg_dat_w;
			end
			own_dsp: begin
				loc_cyc = dsp_cyc;
				loc_stb = dsp_stb;
				loc_we = dsp_we;
				loc_adr = dsp_adr;
				loc_dat_w = dsp_dat_w;
			end
			default: begin
				loc_cyc = 1'b0;
			end
		endcase
	end

	// response steered back to the owner, other side sees nothing
	assign cfg_ack = loc_ack & (owner == own_cfg);
	assign dsp_ack = loc_ack & (owner == own_dsp);
	assign cfg_dat_r = (owner == own_cfg) ? loc_dat_r : '0;
	assign dsp_dat_r = (owner == own_dsp) ? loc_dat_r : '0;

endmodule

`default_nettype wire

/* regbank/reset_regbank.sv */
`default_nettype none

module reset_regbank #(
	parameter int num_cfg_resets = 16,
	parameter int num_dsp_resets = 8
) (
	input wire pl_clk0,
	input wire rst_n,

	// local bus slave
	input wire loc_cyc,
	input wire loc_stb,
	input wire loc_we,
	input wire [rfsim_pkg::wb_addr_w-1:0] loc_adr,
	input wire [rfsim_pkg::wb_data_w-1:0] loc_dat_w,
	output logic [rfsim_pkg::wb_data_w-1:0] loc_dat_r,
	output logic loc_ack,

	// active-low subsystem resets and loopback control
	output logic [num_cfg_resets-1:0] cfg_resetn,
	output logic [num_dsp_resets-1:0] dsp_resetn,
	output logic loop_en
);

	logic [num_cfg_resets-1:0] cfg_q;
	logic [num_dsp_resets-1:0] dsp_q;
	logic loop_en_q;
	logic req;

	// new request only while ack is low, gives one ack per access
	assign req = loc_cyc & loc_stb & ~loc_ack;

	always_ff @(posedge pl_clk0 or negedge rst_n) begin
		if (!rst_n) begin
			loc_ack <= 1'b0;
			cfg_q <= rfsim_pkg::resets_init[num_cfg_resets-1:0];
			dsp_q <= rfsim_pkg::resets_init[num_dsp_resets-1:0];
			loop_en_q <= rfsim_pkg::loop_en_init;
		end else begin
			loc_ack <= req;
			// write lands on the same edge that raises ack
			if (req && loc_we) begin
				case (loc_adr)
					rfsim_pkg::reg_cfg_resets: begin
						cfg_q <= loc_dat_w[num_cfg_resets-1:0];
					end
					rfsim_pkg::reg_dsp_resets: begin
						dsp_q <= loc_dat_w[num_dsp_resets-1:0];
					end
					rfsim_pkg::reg_loop_ctrl: begin
						loop_en_q <= loc_dat_w[0];
					end
					default: begin
						// id is read-only, unmapped writes dropped
						loop_en_q <= loop_en_q;
					end
				endcase
			end
		end
	end

	// read mux, address is held by the host through ack
	always_comb begin
		loc_dat_r = '0;
		case (loc_adr)
			rfsim_pkg::reg_cfg_resets: begin
				// upper bits read as zero
				loc_dat_r[num_cfg_resets-1:0] = cfg_q;
			end
			rfsim_pkg::reg_dsp_resets: begin
				loc_dat_r[num_dsp_resets-1:0] = dsp_q;
			end
			rfsim_pkg::reg_loop_ctrl: begin
				loc_dat_r[0] = loop_en_q;
			end
			rfsim_pkg::reg_id: begin
				loc_dat_r = rfsim_pkg::rfsim_id;
			end
			default: begin
				// unmapped reads return zero
				loc_dat_r = '0;
			end
		endcase
	end

	assign cfg_resetn = cfg_q;
	assign dsp_resetn = dsp_q;
	assign loop_en = loop_en_q;

endmodule

`default_nettype wire

/* loopback/sample_delay_line.sv */
`default_nettype none

module sample_delay_line #(
	parameter int depth = 131
) (
	input wire pl_clk0,
	input wire rst_n,

	input wire in_valid,
	input wire in_last,
	input wire [rfsim_pkg::adc_data_w-1:0] in_data,
	input wire [rfsim_pkg::adc_strb_w-1:0] in_strb,

	output logic out_valid,
	output logic out_last,
	output logic [rfsim_pkg::adc_data_w-1:0] out_data,
	output logic [rfsim_pkg::adc_strb_w-1:0] out_strb
);

	// payload word is last, strobe and data side by side
	localparam int pay_w = 1 + rfsim_pkg::adc_strb_w + rfsim_pkg::adc_data_w;

	logic [depth-1:0] valid_sr;
	logic [pay_w-1:0] pay_sr [depth];

	// valid chain cleared on reset
	// stage 0 takes the new beat
	always_ff @(posedge pl_clk0 or negedge rst_n) begin
		if (!rst_n) begin
			valid_sr <= '0;
		end else begin
			valid_sr[0] <= in_valid;
			for (int i = 1; i < depth; i++) begin
				valid_sr[i] <= valid_sr[i-1];
			end
		end
	end

	// payload chain, no reset
	always_ff @(posedge pl_clk0) begin
		pay_sr[0] <= {in_last, in_strb, in_data};
		for (int i = 1; i < depth; i++) begin
			pay_sr[i] <= pay_sr[i-1];
		end
	end

	// last stage is the output, depth edges after entry
	assign out_valid = valid_sr[depth-1];
	assign {out_last, out_strb, out_data} = pay_sr[depth-1];

endmodule

`default_nettype wire

/* loopback/dac_adc_loopback.sv */
`default_nettype none

module dac_adc_loopback #(
	parameter int loop_delay = 131
) (
	input wire pl_clk0,
	input wire rst_n,
	input wire loop_en,

	// dac side
	input wire dac_valid,
	input wire dac_last,
	input wire rfsim_pkg::dac_beat_u dac_data,
	input wire [rfsim_pkg::dac_strb_w-1:0] dac_strb,

	// adc side
	output logic adc_valid,
	output logic adc_last,
	output logic [rfsim_pkg::adc_data_w-1:0] adc_data,
	output logic [rfsim_pkg::adc_strb_w-1:0] adc_strb
);

	// dac strobe bits per adc strobe bit
	localparam int strb_ratio = rfsim_pkg::dac_strb_w / rfsim_pkg::adc_strb_w;

	logic [rfsim_pkg::adc_data_w-1:0] samples;
	logic [rfsim_pkg::adc_strb_w-1:0] strb_dec;
	logic valid_gated;

	// low sample of each lane, lane 0 lowest
	always_comb begin
		samples = '0;
		for (int k = 0; k < rfsim_pkg::dac_lanes; k++) begin
			samples[k*rfsim_pkg::sample_w +: rfsim_pkg::sample_w] = dac_data.lane[k].sample;
		end
	end

	// keep every fourth strobe bit
	always_comb begin
		strb_dec = '0;
		for (int k = 0; k < rfsim_pkg::adc_strb_w; k++) begin
			strb_dec[k] = dac_strb[k*strb_ratio];
		end
	end

	// enable sampled at entry
	// beats already in flight are not touched
	assign valid_gated = dac_valid & loop_en;

	sample_delay_line #(
		.depth(loop_delay)
	) delay0 (
		.pl_clk0(pl_clk0),
		.rst_n(rst_n),
		.in_valid(valid_gated),
		.in_last(dac_last),
		.in_data(samples),
		.in_strb(strb_dec),
		.out_valid(adc_valid),
		.out_last(adc_last),
		.out_data(adc_data),
		.out_strb(adc_strb)
	);

endmodule

`default_nettype wire

/* src/rfsim_top.sv */
`default_nettype none

module rfsim_top #(
	parameter int num_cfg_resets = 16,
	parameter int num_dsp_resets = 8,
	parameter int loop_delay = 131
) (
	input wire pl_clk0,
	input wire rst_n,

	// cfg host
	input wire cfg_cyc,
	input wire cfg_stb,
	input wire cfg_we,
	input wire [rfsim_pkg::wb_addr_w-1:0] cfg_adr,
	input wire [rfsim_pkg::wb_data_w-1:0] cfg_dat_w,
	output logic [rfsim_pkg::wb_data_w-1:0] cfg_dat_r,
	output logic cfg_ack,

	// dsp host
	input wire dsp_cyc,
	input wire dsp_stb,
	input wire dsp_we,
	input wire [rfsim_pkg::wb_addr_w-1:0] dsp_adr,
	input wire [rfsim_pkg::wb_data_w-1:0] dsp_dat_w,
	output logic [rfsim_pkg::wb_data_w-1:0] dsp_dat_r,
	output logic dsp_ack,

	// dac stream in
	input wire dac_valid,
	input wire dac_last,
	input wire [rfsim_pkg::dac_data_w-1:0] dac_data,
	input wire [rfsim_pkg::dac_strb_w-1:0] dac_strb,

	// adc stream out
	output logic adc_valid,
	output logic adc_last,
	output logic [rfsim_pkg::adc_data_w-1:0] adc_data,
	output logic [rfsim_pkg::adc_strb_w-1:0] adc_strb,

	// subsystem resets, active low
	output logic [num_cfg_resets-1:0] cfg_resetn,
	output logic [num_dsp_resets-1:0] dsp_resetn
);

	// local register bus
	logic loc_cyc;
	logic loc_stb;
	logic loc_we;
	logic [rfsim_pkg::wb_addr_w-1:0] loc_adr;
	logic [rfsim_pkg::wb_data_w-1:0] loc_dat_w;
	logic [rfsim_pkg::wb_data_w-1:0] loc_dat_r;
	logic loc_ack;
	// regbank to loopback
	logic loop_en;

	wb_arbiter arb0 (
		.pl_clk0(pl_clk0),
		.rst_n(rst_n),
		.cfg_cyc(cfg_cyc),
		.cfg_stb(cfg_stb),
		.cfg_we(cfg_we),
		.cfg_adr(cfg_adr),
		.cfg_dat_w(cfg_dat_w),
		.cfg_dat_r(cfg_dat_r),
		.cfg_ack(cfg_ack),
		.dsp_cyc(dsp_cyc),
		.dsp_stb(dsp_stb),
		.dsp_we(dsp_we),
		.dsp_adr(dsp_adr),
		.dsp_dat_w(dsp_dat_w),
		.dsp_dat_r(dsp_dat_r),
		.dsp_ack(dsp_ack),
		.loc_cyc(loc_cyc),
		.loc_stb(loc_stb),
		.loc_we(loc_we),
		.loc_adr(loc_adr),
		.loc_dat_w(loc_dat_w),
		.loc_dat_r(loc_dat_r),
		.loc_ack(loc_ack)
	);

	reset_regbank #(
		.num_cfg_resets(num_cfg_resets),
		.num_dsp_resets(num_dsp_resets)
	) regs0 (
		.pl_clk0(pl_clk0),
		.rst_n(rst_n),
		.loc_cyc(loc_cyc),
		.loc_stb(loc_stb),
		.loc_we(loc_we),
		.loc_adr(loc_adr),
		.loc_dat_w(loc_dat_w),
		.loc_dat_r(loc_dat_r),
		.loc_ack(loc_ack),
		.cfg_resetn(cfg_resetn),
		.dsp_resetn(dsp_resetn),
		.loop_en(loop_en)
	);

	// flat dac bus lands on the union port
	dac_adc_loopback #(
		.loop_delay(loop_delay)
	) loop0 (
		.pl_clk0(pl_clk0),
		.rst_n(rst_n),
		.loop_en(loop_en),
		.dac_valid(dac_valid),
		.dac_last(dac_last),
		.dac_data(dac_data),
		.dac_strb(dac_strb),
		.adc_valid(adc_valid),
		.adc_last(adc_last),
		.adc_data(adc_data),
		.adc_strb(adc_strb)
	);

endmodule

`default_nettype wire

/* test/rfsim_tb.sv */
`default_nettype none

module rfsim_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_cfg_resets = 16;
	localparam int num_dsp_resets = 8;
	localparam int loop_delay = 131;
	localparam int ack_timeout = 16;
	// expected adc word is last, strobe and data side by side
	localparam int exp_w = 1 + rfsim_pkg::adc_strb_w + rfsim_pkg::adc_data_w;

	logic pl_clk0;
	logic rst_n;
	logic cfg_cyc;
	logic cfg_stb;
	logic cfg_we;
	logic [rfsim_pkg::wb_addr_w-1:0] cfg_adr;
	logic [rfsim_pkg::wb_data_w-1:0] cfg_dat_w;
	logic [rfsim_pkg::wb_data_w-1:0] cfg_dat_r;
	logic cfg_ack;
	logic dsp_cyc;
	logic dsp_stb;
	logic dsp_we;
	logic [rfsim_pkg::wb_addr_w-1:0] dsp_adr;
	logic [rfsim_pkg::wb_data_w-1:0] dsp_dat_w;
	logic [rfsim_pkg::wb_data_w-1:0] dsp_dat_r;
	logic dsp_ack;
	logic dac_valid;
	logic dac_last;
	logic [rfsim_pkg::dac_data_w-1:0] dac_data;
	logic [rfsim_pkg::dac_strb_w-1:0] dac_strb;
	logic adc_valid;
	logic adc_last;
	logic [rfsim_pkg::adc_data_w-1:0] adc_data;
	logic [rfsim_pkg::adc_strb_w-1:0] adc_strb;
	logic [num_cfg_resets-1:0] cfg_resetn;
	logic [num_dsp_resets-1:0] dsp_resetn;

	integer seed;
	int err_cnt = 0;
	int err_mark = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int edge_cnt = 0;
	// loopback disabled and drained, no adc beat allowed
	bit quiet = 1'b0;
	// scoreboard, expected word and the edge it entered on
	logic [exp_w-1:0] exp_q[$];
	int entry_q[$];

	rfsim_top #(
		.num_cfg_resets(num_cfg_resets),
		.num_dsp_resets(num_dsp_resets),
		.loop_delay(loop_delay)
	) dut0 (.*);

	initial begin
		pl_clk0 = 1'b0;
		forever #10 pl_clk0 = ~pl_clk0;
	end

	// rising edge count, read on the falling edge
	always @(posedge pl_clk0) edge_cnt <= edge_cnt + 1;

	task automatic report_mismatch(input string msg);
		err_cnt++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic begin_test();
		err_mark = err_cnt;
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == err_mark) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - err_mark);
		end
	endtask

	// word with everything above bit n-1 cleared
	function automatic logic [31:0] low_bits(input logic [31:0] word, input int n);
		logic [31:0] res;
		res = '0;
		for (int i = 0; i < n; i++)
			res[i] = word[i];
		return res;
	endfunction

	// adc sample k from lane k bits 15..0, strobe k from dac strobe 4k
	function automatic logic [exp_w-1:0] expected_adc(input logic last,
			input logic [255:0] data, input logic [31:0] strb);
		logic [63:0] samples;
		logic [7:0] strb_k;
		for (int k = 0; k < 4; k++)
			samples[16*k +: 16] = data[64*k +: 16];
		for (int k = 0; k < 8; k++)
			strb_k[k] = strb[4*k];
		return {last, strb_k, samples};
	endfunction

	task automatic drive_host(input bit use_dsp, input logic active, input logic we,
			input logic [3:0] adr, input logic [31:0] wdata);
		if (use_dsp) begin
			dsp_cyc = active;
			dsp_stb = active;
			dsp_we = we;
			dsp_adr = adr;
			dsp_dat_w = wdata;
		end else begin
			cfg_cyc = active;
			cfg_stb = active;
			cfg_we = we;
			cfg_adr = adr;
			cfg_dat_w = wdata;
		end
	endtask

	// one classic cycle, edges counts rising edges up to the ack
	task automatic host_access(input bit use_dsp, input logic we, input logic [3:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata, output int edges);
		logic ack;
		edges = 0;
		ack = 1'b0;
		@(negedge pl_clk0);
		drive_host(use_dsp, 1'b1, we, adr, wdata);
		while (!ack) begin
			@(negedge pl_clk0);
			edges++;
			ack = use_dsp ? dsp_ack : cfg_ack;
			if (!ack && edges > ack_timeout)
				abort_run("timed out waiting for a host port ack");
		end
		rdata = use_dsp ? dsp_dat_r : cfg_dat_r;
		// cyc dropped, next access waits a full cycle
		drive_host(use_dsp, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge pl_clk0);
			n++;
			if (n > loop_delay + 16)
				abort_run("timed out waiting for the loopback to return all DAC beats");
		end
	endtask

	task automatic send_beats(input int count, input bit track);
		for (int i = 0; i < count; i++) begin
			@(negedge pl_clk0);
			for (int w = 0; w < 8; w++)
				dac_data[32*w +: 32] = $random(seed);
			dac_strb = $random(seed);
			// mostly back to back, some gaps
			dac_valid = (i == count - 1) || (($random(seed) & 3) != 0);
			dac_last = (i == count - 1) || (($random(seed) & 7) == 0);
			if (track && dac_valid) begin
				exp_q.push_back(expected_adc(dac_last, dac_data, dac_strb));
				entry_q.push_back(edge_cnt + 1);
			end
		end
		@(negedge pl_clk0);
		dac_valid = 1'b0;
		dac_last = 1'b0;
	endtask

	// adc monitor against the scoreboard
	always @(negedge pl_clk0) begin
		logic [exp_w-1:0] exp_word;
		int entry;
		if (rst_n && adc_valid) begin
			if (exp_q.size() == 0) begin
				report_mismatch("adc beat with no DAC beat pending");
			end else begin
				exp_word = exp_q.pop_front();
				entry = entry_q.pop_front();
				assert ({adc_last, adc_strb, adc_data} == exp_word)
					else report_mismatch($sformatf("adc beat %h, expected %h",
						{adc_last, adc_strb, adc_data}, exp_word));
				// first sampled on edge entry + loop_delay
				assert (edge_cnt + 1 == entry + loop_delay)
					else report_mismatch($sformatf("adc beat after %0d edges",
						edge_cnt + 1 - entry));
			end
		end
	end

	ack_exclusive: assert property (@(negedge pl_clk0) disable iff (!rst_n)
		!(cfg_ack && dsp_ack)) else report_mismatch("ack on both host ports in one cycle");
	cfg_ack_owned: assert property (@(negedge pl_clk0) disable iff (!rst_n)
		cfg_ack |-> (cfg_cyc && cfg_stb)) else report_mismatch("cfg ack without a request");
	dsp_ack_owned: assert property (@(negedge pl_clk0) disable iff (!rst_n)
		dsp_ack |-> (dsp_cyc && dsp_stb)) else report_mismatch("dsp ack without a request");
	cfg_ack_single: assert property (@(negedge pl_clk0) disable iff (!rst_n)
		cfg_ack |=> !cfg_ack) else report_mismatch("cfg ack longer than one cycle");
	loop_quiet: assert property (@(negedge pl_clk0) disable iff (!rst_n)
		quiet |-> !adc_valid) else report_mismatch("adc_valid while loopback disabled");

	initial begin
		logic [31:0] word;
		logic [31:0] word2;
		logic [31:0] rd;
		logic [31:0] rd2;
		int edges;
		int edges2;
		seed = 32'hde5d;
		rst_n = 1'b0;
		drive_host(1'b0, 1'b0, 1'b0, '0, '0);
		drive_host(1'b1, 1'b0, 1'b0, '0, '0);
		dac_valid = 1'b0;
		dac_last = 1'b0;
		dac_data = '0;
		dac_strb = '0;
		repeat (8) @(negedge pl_clk0);
		rst_n = 1'b1;

		// 1. reset state
		begin_test();
		@(negedge pl_clk0);
		assert (cfg_resetn == '0) else report_mismatch("cfg_resetn not zero after reset");
		assert (dsp_resetn == '0) else report_mismatch("dsp_resetn not zero after reset");
		assert (!adc_valid && !cfg_ack && !dsp_ack)
			else report_mismatch("adc_valid or an ack high after reset");
		finish_test("reset values");

		// 2. cfg resets through the cfg port
		begin_test();
		repeat (4) begin
			word = $random(seed);
			host_access(1'b0, 1'b1, rfsim_pkg::reg_cfg_resets, word, rd, edges);
			assert (edges == 2) else report_mismatch($sformatf("cfg ack after %0d edges", edges));
			assert (cfg_resetn == word[num_cfg_resets-1:0])
				else report_mismatch($sformatf("cfg_resetn %h for write %h", cfg_resetn, word));
			host_access(1'b0, 1'b0, rfsim_pkg::reg_cfg_resets, '0, rd, edges);
			assert (rd == low_bits(word, num_cfg_resets))
				else report_mismatch($sformatf("cfg reset readback %h for write %h", rd, word));
		end
		finish_test("cfg reset register");

		// 3. dsp resets, id and unmapped word through the dsp port
		begin_test();
		word = $random(seed);
		host_access(1'b1, 1'b1, rfsim_pkg::reg_dsp_resets, word, rd, edges);
		assert (dsp_resetn == word[num_dsp_resets-1:0])
			else report_mismatch($sformatf("dsp_resetn %h for write %h", dsp_resetn, word));
		host_access(1'b1, 1'b0, rfsim_pkg::reg_id, '0, rd, edges);
		assert (rd == rfsim_pkg::rfsim_id) else report_mismatch($sformatf("id read %h", rd));
		host_access(1'b1, 1'b1, 4'd11, 32'hffff_ffff, rd, edges);
		host_access(1'b1, 1'b0, 4'd11, '0, rd, edges);
		assert (rd == '0) else report_mismatch($sformatf("unmapped read %h", rd));
		finish_test("dsp register and id");

		// 4. both hosts in the same cycle, cfg has priority
		begin_test();
		word = $random(seed);
		word2 = $random(seed);
		fork
			host_access(1'b0, 1'b1, rfsim_pkg::reg_cfg_resets, word, rd, edges);
			host_access(1'b1, 1'b1, rfsim_pkg::reg_dsp_resets, word2, rd2, edges2);
		join
		assert (edges == 2 && edges2 > edges)
			else report_mismatch($sformatf("grant order cfg %0d dsp %0d", edges, edges2));
		fork
			host_access(1'b0, 1'b0, rfsim_pkg::reg_dsp_resets, '0, rd, edges);
			host_access(1'b1, 1'b0, rfsim_pkg::reg_cfg_resets, '0, rd2, edges2);
		join
		assert (rd == low_bits(word2, num_dsp_resets))
			else report_mismatch($sformatf("contended dsp readback %h", rd));
		assert (rd2 == low_bits(word, num_cfg_resets))
			else report_mismatch($sformatf("contended cfg readback %h", rd2));
		finish_test("contended access");

		// 5. loopback burst
		begin_test();
		host_access(1'b0, 1'b1, rfsim_pkg::reg_loop_ctrl, 32'd1, rd, edges);
		send_beats(48, 1'b1);
		wait_drain();
		finish_test("loopback burst");

		// 6. disabled loopback stays silent
		begin_test();
		host_access(1'b1, 1'b1, rfsim_pkg::reg_loop_ctrl, 32'd0, rd, edges);
		host_access(1'b1, 1'b0, rfsim_pkg::reg_loop_ctrl, '0, rd, edges);
		assert (rd == '0) else report_mismatch($sformatf("loop control read %h", rd));
		wait_drain();
		quiet = 1'b1;
		send_beats(20, 1'b0);
		repeat (loop_delay + 8) @(negedge pl_clk0);
		quiet = 1'b0;
		finish_test("loopback disabled");

		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rfsim_top.f */
common/rfsim_pkg.sv
src/wb_arbiter.sv
regbank/reset_regbank.sv
loopback/sample_delay_line.sv
loopback/dac_adc_loopback.sv
src/rfsim_top.sv
test/rfsim_tb.sv

/* Bender.yml */
package:
  name: rfsim

sources:
  # shared package first
  - common/rfsim_pkg.sv
  # rtl in compile order
  - src/wb_arbiter.sv
  - regbank/reset_regbank.sv
  - loopback/sample_delay_line.sv
  - loopback/dac_adc_loopback.sv
  - src/rfsim_top.sv
  # testbench
  - target: test
    files:
      - test/rfsim_tb.sv
